// File: logic/alaw_pkg.sv
package alaw_pkg;

	// Input sample format
	parameter int sample_width = 24;

	// Segment search range
	parameter int segment_count = 19;

	// Segment 0 covers magnitudes below this value and segment k ends at segment_span << k.
	// The base of a segment is half its end.
	parameter int segment_span = 32;

	// Output code fields
	parameter int segment_bits = 7;
	parameter int mantissa_bits = 8;
	parameter int code_bits = mantissa_bits + segment_bits;

	typedef logic [segment_bits-1:0] segment_t;

	typedef logic [mantissa_bits-1:0] mantissa_t;

	// Mantissa in the upper bits, segment in the lower bits
	typedef logic [code_bits-1:0] code_t;

endpackage

// File: logic/compress_state_pkg.sv
package compress_state_pkg;

	// One pass through these states per accepted sample
	typedef enum logic [2:0] {
		idle,
		fold_sign,
		find_segment,
		subtract_base,
		divide_step,
		emit
	} state_t;

endpackage

// File: logic/sign_magnitude.sv
`timescale 1ns/1ns

module sign_magnitude #(
	parameter int sample_width = 24
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    load,
	input  logic                    fold,
	input  logic [sample_width-1:0] sample,
	output logic                    positive,
	output logic [sample_width-1:0] magnitude
);

	logic [sample_width-1:0] held_sample;

	// Sample is taken on the accepting edge
	always_ff @(posedge clk) begin
		if (load) begin
			held_sample <= sample;
		end
	end

	// Most negative input folds to 2^(sample_width-1) as an unsigned magnitude
	always_ff @(posedge clk) begin
		if (!reset) begin
			positive <= 1'b1;
			magnitude <= '0;
		end else if (fold) begin
			positive <= ~held_sample[sample_width-1];
			magnitude <= held_sample[sample_width-1] ? (~held_sample + 1'b1) : held_sample;
		end
	end

endmodule

// File: logic/segment_finder.sv
`timescale 1ns/1ns

module segment_finder #(
	parameter int sample_width = 24,
	parameter int segment_count = 19
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    find,
	input  logic [sample_width-1:0] magnitude,
	output alaw_pkg::segment_t      segment
);

	alaw_pkg::segment_t next_segment;

	// Walk down from the top so the smallest matching segment wins
	always_comb begin
		logic [63:0] limit;
		next_segment = '0;
		for (int k = segment_count - 1; k >= 0; k--) begin
			limit = 64'(alaw_pkg::segment_span) << k;
			if (64'(magnitude) < limit) begin
				next_segment = alaw_pkg::segment_t'(k);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			segment <= '0;
		end else if (find) begin
			segment <= next_segment;
		end
	end

endmodule

// File: logic/mantissa_quantizer.sv
`timescale 1ns/1ns

module mantissa_quantizer #(
	parameter int sample_width = 24
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    subtract,
	input  logic                    divide,
	input  logic [sample_width-1:0] magnitude,
	input  alaw_pkg::segment_t      segment,
	output alaw_pkg::mantissa_t     mantissa
);

	localparam logic [sample_width-1:0] base_unit = sample_width'(alaw_pkg::segment_span / 2);

	logic [sample_width-1:0] base;
	logic [sample_width-1:0] offset;
	logic                    underflow;
	alaw_pkg::segment_t      step_shift;
	logic [sample_width-1:0] quotient;

	assign base = base_unit << segment;

	// Segment 0 shares the step of segment 1
	assign step_shift = (segment == '0) ? alaw_pkg::segment_t'(1) : segment;
	assign quotient = offset >> step_shift;

	always_ff @(posedge clk) begin
		if (!reset) begin
			offset <= '0;
			underflow <= 1'b0;
		end else if (subtract) begin
			offset <= magnitude - base;
			underflow <= (magnitude < base);
		end
	end

	// A quotient that does not fit the field codes as zero
	always_ff @(posedge clk) begin
		if (!reset) begin
			mantissa <= '0;
		end else if (divide) begin
			if (underflow || (|quotient[sample_width-1:alaw_pkg::mantissa_bits])) begin
				mantissa <= '0;
			end else begin
				mantissa <= quotient[alaw_pkg::mantissa_bits-1:0];
			end
		end
	end

endmodule

// File: logic/code_packer.sv
`timescale 1ns/1ns

module code_packer (
	input  logic                clk,
	input  logic                reset,
	input  logic                emit,
	input  logic                positive,
	input  alaw_pkg::segment_t  segment,
	input  alaw_pkg::mantissa_t mantissa,
	output alaw_pkg::code_t     code
);

	alaw_pkg::code_t packed_code;
	alaw_pkg::code_t negated_code;

	assign packed_code = {mantissa, segment};
	assign negated_code = ~packed_code + 1'b1;

	// Code holds until the next emit
	always_ff @(posedge clk) begin
		if (!reset) begin
			code <= '0;
		end else if (emit) begin
			if (positive) begin
				code <= packed_code;
			end else begin
				code <= negated_code;
			end
		end
	end

endmodule

// File: logic/compress_control.sv
`timescale 1ns/1ns

module compress_control (
	input  logic clk,
	input  logic reset,
	input  logic start,
	output logic load,
	output logic fold,
	output logic find,
	output logic subtract,
	output logic divide,
	output logic emit,
	output logic done
);

	compress_state_pkg::state_t state;
	compress_state_pkg::state_t next_state;

	// Start only counts in idle
	assign load = (state == compress_state_pkg::idle) && start;
	assign fold = (state == compress_state_pkg::fold_sign);
	assign find = (state == compress_state_pkg::find_segment);
	assign subtract = (state == compress_state_pkg::subtract_base);
	assign divide = (state == compress_state_pkg::divide_step);
	assign emit = (state == compress_state_pkg::emit);

	always_comb begin
		next_state = state;
		case (state)
			compress_state_pkg::idle: begin
				if (start) begin
					next_state = compress_state_pkg::fold_sign;
				end
			end
			compress_state_pkg::fold_sign: next_state = compress_state_pkg::find_segment;
			compress_state_pkg::find_segment: next_state = compress_state_pkg::subtract_base;
			compress_state_pkg::subtract_base: next_state = compress_state_pkg::divide_step;
			compress_state_pkg::divide_step: next_state = compress_state_pkg::emit;
			default: next_state = compress_state_pkg::idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= compress_state_pkg::idle;
		end else begin
			state <= next_state;
		end
	end

	// Done rises as the code is registered and drops when a new sample is taken
	always_ff @(posedge clk) begin
		if (!reset) begin
			done <= 1'b0;
		end else if (load) begin
			done <= 1'b0;
		end else if (emit) begin
			done <= 1'b1;
		end
	end

endmodule

// File: logic/alaw_compressor.sv
`timescale 1ns/1ns

module alaw_compressor (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [alaw_pkg::sample_width-1:0] sample,
	input  logic                              start,
	output alaw_pkg::code_t                   code,
	output logic                              done
);

	logic load;
	logic fold;
	logic find;
	logic subtract;
	logic divide;
	logic emit;

	logic                              positive;
	logic [alaw_pkg::sample_width-1:0] magnitude;
	alaw_pkg::segment_t                segment;
	alaw_pkg::mantissa_t               mantissa;

	compress_control u_control (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.load     (load),
		.fold     (fold),
		.find     (find),
		.subtract (subtract),
		.divide   (divide),
		.emit     (emit),
		.done     (done)
	);

	sign_magnitude #(
		.sample_width (alaw_pkg::sample_width)
	) u_sign_magnitude (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.fold      (fold),
		.sample    (sample),
		.positive  (positive),
		.magnitude (magnitude)
	);

	segment_finder #(
		.sample_width  (alaw_pkg::sample_width),
		.segment_count (alaw_pkg::segment_count)
	) u_segment_finder (
		.clk       (clk),
		.reset     (reset),
		.find      (find),
		.magnitude (magnitude),
		.segment   (segment)
	);

	mantissa_quantizer #(
		.sample_width (alaw_pkg::sample_width)
	) u_mantissa_quantizer (
		.clk       (clk),
		.reset     (reset),
		.subtract  (subtract),
		.divide    (divide),
		.magnitude (magnitude),
		.segment   (segment),
		.mantissa  (mantissa)
	);

	code_packer u_code_packer (
		.clk      (clk),
		.reset    (reset),
		.emit     (emit),
		.positive (positive),
		.segment  (segment),
		.mantissa (mantissa),
		.code     (code)
	);

endmodule

// File: sim/tb_alaw_compressor.sv
`timescale 1ns/1ns

module tb_alaw_compressor;

	typedef logic [alaw_pkg::sample_width-1:0] sample_t;

	localparam int done_timeout = 20;

	logic            clk;
	logic            reset;
	sample_t         sample;
	logic            start;
	alaw_pkg::code_t code;
	logic            done;

	int mismatches;
	int timeouts;

	alaw_compressor DUT (
		.clk    (clk),
		.reset  (reset),
		.sample (sample),
		.start  (start),
		.code   (code),
		.done   (done)
	);

	always #5 clk = ~clk;

	// Reference model written straight from the code format rules
	function automatic alaw_pkg::code_t model_code(input sample_t value);
		longint magnitude;
		longint base;
		longint step;
		longint quotient;
		int segment;
		bit found;
		alaw_pkg::mantissa_t mantissa;
		alaw_pkg::code_t result;
		magnitude = longint'($signed(value));
		if (magnitude < 0) begin
			magnitude = -magnitude;
		end
		segment = 0;
		found = 1'b0;
		for (int k = 0; k <= 18; k++) begin
			if (!found && magnitude < 32 * (longint'(1) << k)) begin
				segment = k;
				found = 1'b1;
			end
		end
		step = (segment == 0) ? 2 : (longint'(1) << segment);
		base = 16 * (longint'(1) << segment);
		if (magnitude < base) begin
			mantissa = '0;
		end else begin
			quotient = (magnitude - base) / step;
			mantissa = (quotient > 255) ? '0 : alaw_pkg::mantissa_t'(quotient);
		end
		result = {mantissa, alaw_pkg::segment_t'(segment)};
		if (value[alaw_pkg::sample_width-1]) begin
			result = '0 - result;
		end
		return result;
	endfunction

	task automatic check_code(input string name, input alaw_pkg::code_t expected,
			input alaw_pkg::code_t actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			mismatches++;
		end
	endtask

	task automatic check_done(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected done %b, actual %b", name, expected, actual);
			mismatches++;
		end
	endtask

	task automatic wait_for_done(input string name);
		int cycles;
		compress_state_pkg::state_t stuck_state;
		cycles = 0;
		while (done !== 1'b1 && cycles < done_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (done !== 1'b1) begin
			stuck_state = DUT.u_control.state;
			$display("Timeout in %s: done did not rise within %0d cycles, controller in %s",
				name, done_timeout, stuck_state.name());
			timeouts++;
		end
	endtask

	task automatic compress_sample(input string name, input sample_t value,
			output alaw_pkg::code_t result);
		@(negedge clk);
		sample = value;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// Changing the input after the accepting edge must not affect the result
		sample = ~value;
		wait_for_done(name);
		result = code;
	endtask

	task automatic test_reset();
		check_done("test_reset", 1'b0, done);
		check_code("test_reset", '0, code);
	endtask

	task automatic test_positive();
		int values[8] = '{0, 15, 16, 31, 32, 1000, 1 << 22, (1 << 23) - 1};
		string name;
		alaw_pkg::code_t result;
		foreach (values[i]) begin
			name = $sformatf("test_positive %0d", values[i]);
			compress_sample(name, sample_t'(values[i]), result);
			check_code(name, model_code(sample_t'(values[i])), result);
		end
	endtask

	task automatic test_negative();
		int values[5] = '{-1, -16, -1000, -(1 << 22), -(1 << 23)};
		string name;
		alaw_pkg::code_t result;
		foreach (values[i]) begin
			name = $sformatf("test_negative %0d", values[i]);
			compress_sample(name, sample_t'(values[i]), result);
			check_code(name, model_code(sample_t'(values[i])), result);
		end
		// Most negative sample saturates to a zero code
		check_code("test_negative most negative", '0, result);
	endtask

	task automatic test_timing();
		sample_t value;
		alaw_pkg::code_t expected;
		value = sample_t'(1000);
		expected = model_code(value);
		@(negedge clk);
		sample = value;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_done("test_timing edge 0", 1'b0, done);
		for (int edge_count = 1; edge_count <= 5; edge_count++) begin
			@(negedge clk);
			check_done($sformatf("test_timing edge %0d", edge_count), edge_count == 5, done);
		end
		check_code("test_timing code", expected, code);
		repeat (10) begin
			@(negedge clk);
			check_done("test_timing idle", 1'b1, done);
			check_code("test_timing idle code", expected, code);
		end
		sample = sample_t'(-1000);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_done("test_timing next start", 1'b0, done);
		wait_for_done("test_timing next start");
		check_code("test_timing next code", model_code(sample_t'(-1000)), code);
	endtask

	task automatic test_busy_start();
		sample_t first;
		sample_t second;
		first = sample_t'(1000);
		second = sample_t'(-5000);
		@(negedge clk);
		sample = first;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		@(negedge clk);
		// Offered while the controller is busy
		sample = second;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_for_done("test_busy_start");
		check_code("test_busy_start code", model_code(first), code);
		repeat (3) begin
			@(negedge clk);
			check_done("test_busy_start hold", 1'b1, done);
		end
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_done("test_busy_start restart", 1'b0, done);
		wait_for_done("test_busy_start restart");
		check_code("test_busy_start second code", model_code(second), code);
	endtask

	task automatic test_random();
		sample_t value;
		string name;
		alaw_pkg::code_t result;
		for (int i = 0; i < 200; i++) begin
			value = sample_t'($urandom);
			name = $sformatf("test_random %0d sample %h", i, value);
			compress_sample(name, value, result);
			check_code(name, model_code(value), result);
		end
	endtask

	initial begin
		void'($urandom(72));
		mismatches = 0;
		timeouts = 0;
		clk = 1'b0;
		reset = 1'b0;
		start = 1'b0;
		sample = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
		test_reset();
		test_positive();
		test_negative();
		test_timing();
		test_busy_start();
		test_random();
		$display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
logic/alaw_pkg.sv
logic/compress_state_pkg.sv
logic/sign_magnitude.sv
logic/segment_finder.sv
logic/mantissa_quantizer.sv
logic/code_packer.sv
logic/compress_control.sv
logic/alaw_compressor.sv
sim/tb_alaw_compressor.sv

// File: Makefile
SOURCES = all.f $(wildcard logic/*.sv) $(wildcard sim/*.sv)

run: obj_dir/Vtb_alaw_compressor
	./obj_dir/Vtb_alaw_compressor > sim.log
	@cat sim.log
	@grep -q "Result: PASSED" sim.log

obj_dir/Vtb_alaw_compressor: $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module tb_alaw_compressor \
		-f all.f -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
